// File: sources.f
logic/arb_pkg.sv
logic/a_write_buffer.sv
logic/a_master_port.sv
logic/a_controller.sv
logic/a_bus_mux.sv
logic/a_arbiter.sv
bench/arbiter_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module arbiter_tb -f sources.f -o arbiter_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/arbiter_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Errors found" "$LOG"; then
  exit 1
fi
exit 0

// File: bench/arbiter_tb.sv
`timescale 1ns/1ps

module arbiter_tb;

  import arb_pkg::*;

  localparam int NO_MASTERS = 2;
  localparam int NO_SLAVES  = 3;
  localparam int HOLD_LIMIT = 40;

  // rough cycle budget of each scenario
  localparam int LEN_RESET  = 20;
  localparam int LEN_SINGLE = 60;
  localparam int LEN_NAK    = 80;
  localparam int LEN_SHARED = 3 * 150;
  localparam int LEN_SPLIT  = 200;
  localparam int WATCHDOG_CYCLES =
    4 * (LEN_RESET + LEN_SINGLE + LEN_NAK + LEN_SHARED + LEN_SPLIT);

  logic                  clk;
  logic                  rstN;
  logic [NO_MASTERS-1:0] master_in;
  logic [NO_MASTERS-1:0] master_out;
  logic [NO_SLAVES:1]    slave_out;

  logic [31:0]           lfsr;
  logic [2:0]            exp_q [NO_MASTERS][$];
  int                    code_cnt [NO_MASTERS];
  int                    cap_cnt [NO_MASTERS];
  logic [2:0]            cap_bits [NO_MASTERS];
  int                    tgt [NO_MASTERS];
  logic                  route_on [NO_SLAVES+1];
  int                    route_m [NO_SLAVES+1];
  logic                  busy_tb [NO_SLAVES+1];
  logic [NO_MASTERS-1:0] prev_in;
  logic [NO_MASTERS-1:0] prev_out;
  int                    last_grant;
  int                    exp_first;
  logic                  first_pending;

  a_arbiter #(
    .NO_MASTERS (NO_MASTERS),
    .NO_SLAVES  (NO_SLAVES),
    .HOLD_LIMIT (HOLD_LIMIT)
  ) a_arbiter_inst (
    .clk        (clk),
    .rstN       (rstN),
    .master_in  (master_in),
    .master_out (master_out),
    .slave_out  (slave_out)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////
  // reference model
  ////////////////////

  function automatic logic [31:0] galois_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ 32'h80200003;
    return n;
  endfunction

  // code as seen from its first high bit onward
  function automatic logic [2:0] expected_capture(input logic [2:0] code);
    logic [2:0] c;
    c = code;
    for (int i = 0; i < 3; i++) begin
      if (c != 3'b000 && !c[0]) c = c >> 1;
    end
    return c;
  endfunction

  // routed slave repeats the owner's bit one cycle late
  function automatic logic expected_slave(input logic on, input logic prev_bit);
    return on ? prev_bit : 1'b0;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      $display("Errors found");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic take_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = galois_step(lfsr);
      v = (v << 1) | int'(lfsr[0]);
    end
  endtask

  ////////////////////
  // master models
  ////////////////////

  task automatic drive_bit(input int m, input logic b);
    @(posedge clk);
    master_in[m] <= b;
  endtask

  task automatic await_code(input int m, input logic [2:0] code);
    int seen;
    seen = code_cnt[m];
    exp_q[m].push_back(code);
    wait (code_cnt[m] > seen);
  endtask

  task automatic send_request(input int m, input int sid);
    logic [4:0] pattern;
    pattern = {3'b111, sid[1:0]};
    tgt[m] = sid;
    for (int i = 4; i >= 0; i--) drive_bit(m, pattern[i]);
    drive_bit(m, 1'b0);
  endtask

  task automatic nak_grant(input int m, input int sid);
    send_request(m, sid);
    await_code(m, GRANT_NEW);
    last_grant = m;
    drive_bit(m, 1'b0);
    drive_bit(m, 1'b1);
    drive_bit(m, 1'b1);
    drive_bit(m, 1'b0);
    repeat (8) @(posedge clk);
  endtask

  task automatic run_master(input int m, input int sid, input logic do_req,
                            input logic [2:0] grant, input logic split);
    int  n_ones;
    int  n_zeros;
    time t0;
    if (do_req) send_request(m, sid);
    await_code(m, grant);
    if (first_pending) begin
      check_value("first grant master", m, exp_first);
      first_pending = 1'b0;
    end
    check_value("slave busy at grant", busy_tb[sid], 0);
    busy_tb[sid] = 1'b1;
    last_grant = m;
    // ack then leave the line high
    drive_bit(m, 1'b1);
    drive_bit(m, 1'b0);
    drive_bit(m, 1'b1);
    await_code(m, START_COM);
    t0 = $time;
    if (split) begin
      await_code(m, STOP_SPLIT);
      check_value("split after hold limit", ((($time - t0) / 8) >= HOLD_LIMIT), 1);
      drive_bit(m, 1'b0);
      drive_bit(m, 1'b1);
      drive_bit(m, 1'b0);
      repeat (3) @(posedge clk);
    end else begin
      take_bits(3, n_ones);
      take_bits(3, n_zeros);
      repeat (n_ones + 1) drive_bit(m, 1'b1);
      repeat (n_zeros + 1) drive_bit(m, 1'b0);
      // end bits
      drive_bit(m, 1'b1);
      drive_bit(m, 1'b0);
      @(posedge clk);
    end
    route_on[sid] = 1'b0;
    busy_tb[sid]  = 1'b0;
  endtask

  ////////////////////
  // compare process
  ////////////////////

  always @(negedge clk) begin : compare_proc
    if (rstN) begin
      for (int m = 0; m < NO_MASTERS; m++) begin
        if (cap_cnt[m] == 0 && master_out[m] && !prev_out[m]) begin
          cap_bits[m][0] = 1'b1;
          cap_cnt[m] = 1;
          // routing starts with the first start bit
          if (exp_q[m].size() > 0 && exp_q[m][0] == START_COM) begin
            route_on[tgt[m]] = 1'b1;
            route_m[tgt[m]]  = m;
          end
        end else if (cap_cnt[m] > 0) begin
          cap_bits[m][cap_cnt[m]] = master_out[m];
          cap_cnt[m]++;
          if (cap_cnt[m] == 3) begin
            if (exp_q[m].size() == 0) begin
              $display("unexpected code on master_out[%0d] at %0t", m, $time);
              $display("Errors found");
              $fatal(1, "unexpected code");
            end else begin
              check_value($sformatf("master_out[%0d] code", m), 32'(cap_bits[m]),
                          32'(expected_capture(exp_q[m].pop_front())));
              cap_cnt[m] = 0;
              code_cnt[m]++;
            end
          end
        end
      end
      for (int s = 1; s <= NO_SLAVES; s++) begin
        check_value($sformatf("slave_out[%0d]", s), 32'(slave_out[s]),
                    32'(expected_slave(route_on[s], prev_in[route_m[s]])));
      end
    end
    prev_in  = master_in;
    prev_out = master_out;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired before all scenarios finished at %0t", $time);
    $display("Errors found");
    $fatal(1, "timeout");
  end

  initial begin : stimulus
    rstN          = 1'b0;
    master_in     = '0;
    lfsr          = 32'hd31fb80f;
    last_grant    = 0;
    exp_first     = 0;
    first_pending = 1'b0;
    prev_in       = '0;
    prev_out      = '0;
    for (int m = 0; m < NO_MASTERS; m++) begin
      code_cnt[m] = 0;
      cap_cnt[m]  = 0;
      cap_bits[m] = '0;
      tgt[m]      = 0;
    end
    for (int s = 0; s <= NO_SLAVES; s++) begin
      route_on[s] = 1'b0;
      route_m[s]  = 0;
      busy_tb[s]  = 1'b0;
    end
    repeat (5) @(posedge clk);
    rstN <= 1'b1;
    // idle lines after reset
    repeat (10) begin
      @(negedge clk);
      check_value("master_out", 32'(master_out), 0);
    end
    run_master(0, 2, 1'b1, GRANT_NEW, 1'b0);
    repeat (8) @(posedge clk);
    nak_grant(1, 3);
    nak_grant(1, 3);
    // two masters on one slave
    for (int r = 0; r < 3; r++) begin
      // a lone nak grant sets who goes first
      nak_grant((r + 1) % NO_MASTERS, 3);
      exp_first     = (last_grant + 1) % NO_MASTERS;
      first_pending = 1'b1;
      fork
        run_master(0, 1, 1'b1, GRANT_NEW, 1'b0);
        run_master(1, 1, 1'b1, GRANT_NEW, 1'b0);
      join
      repeat (8) @(posedge clk);
    end
    // long hold gets split
    fork
      begin
        run_master(0, 1, 1'b1, GRANT_NEW, 1'b1);
        run_master(0, 1, 1'b0, GRANT_OLD, 1'b0);
      end
      begin
        repeat (20) @(posedge clk);
        run_master(1, 1, 1'b1, GRANT_NEW, 1'b0);
      end
    join
    repeat (8) @(posedge clk);
    $display("No errors");
    $finish;
  end

endmodule

// File: logic/a_arbiter.sv
`timescale 1ns/1ps

module a_arbiter #(
  parameter int NO_MASTERS = 2,
  parameter int NO_SLAVES  = 3,
  parameter int HOLD_LIMIT = 40
) (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic [NO_MASTERS-1:0] master_in,
  output logic [NO_MASTERS-1:0] master_out,
  output logic [NO_SLAVES:1]    slave_out
);

  import arb_pkg::*;

  // slave ids run 1..NO_SLAVES, 0 means none
  localparam int S_ID_WIDTH = $clog2(NO_SLAVES + 1);
  localparam int M_WIDTH    = idx_width(NO_MASTERS);

  port_status_t [NO_MASTERS-1:0]   status;
  cmd_t [NO_MASTERS-1:0]           cmd;
  logic [NO_SLAVES:1]              grant_valid;
  logic [NO_SLAVES:1][M_WIDTH-1:0] grant_master;

  for (genvar m = 0; m < NO_MASTERS; m++) begin : g_port
    a_master_port #(.S_ID_WIDTH(S_ID_WIDTH)) port_inst (
      .clk      (clk),
      .rstN     (rstN),
      .port_in  (master_in[m]),
      .port_out (master_out[m]),
      .cmd      (cmd[m]),
      .status   (status[m])
    );
  end

  a_controller #(
    .NO_MASTERS (NO_MASTERS),
    .NO_SLAVES  (NO_SLAVES),
    .S_ID_WIDTH (S_ID_WIDTH),
    .HOLD_LIMIT (HOLD_LIMIT)
  ) controller_inst (
    .clk          (clk),
    .rstN         (rstN),
    .status       (status),
    .cmd          (cmd),
    .grant_valid  (grant_valid),
    .grant_master (grant_master)
  );

  a_bus_mux #(.NO_MASTERS(NO_MASTERS), .NO_SLAVES(NO_SLAVES)) bus_mux_inst (
    .clk          (clk),
    .rstN         (rstN),
    .master_in    (master_in),
    .grant_valid  (grant_valid),
    .grant_master (grant_master),
    .slave_out    (slave_out)
  );

endmodule

// File: logic/a_bus_mux.sv
`timescale 1ns/1ps

module a_bus_mux #(
  parameter int NO_MASTERS = 2,
  parameter int NO_SLAVES  = 3
) (
  input  logic                                                  clk,
  input  logic                                                  rstN,
  input  logic [NO_MASTERS-1:0]                                 master_in,
  input  logic [NO_SLAVES:1]                                    grant_valid,
  input  logic [NO_SLAVES:1][arb_pkg::idx_width(NO_MASTERS)-1:0] grant_master,
  output logic [NO_SLAVES:1]                                    slave_out
);

  ////////////////////
  // slave routing
  ////////////////////

  // one register stage per slave line
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      slave_out <= '0;
    end else begin
      for (int s = 1; s <= NO_SLAVES; s++) begin
        if (grant_valid[s]) begin
          slave_out[s] <= master_in[grant_master[s]];
        end else begin
          // no owner, hold the line low
          slave_out[s] <= 1'b0;
        end
      end
    end
  end

endmodule

// File: logic/a_controller.sv
`timescale 1ns/1ps

module a_controller #(
  parameter int NO_MASTERS = 2,
  parameter int NO_SLAVES  = 3,
  parameter int S_ID_WIDTH = 2,
  parameter int HOLD_LIMIT = 40
) (
  input  logic                                                  clk,
  input  logic                                                  rstN,
  input  arb_pkg::port_status_t [NO_MASTERS-1:0]                status,
  output arb_pkg::cmd_t [NO_MASTERS-1:0]                        cmd,
  output logic [NO_SLAVES:1]                                    grant_valid,
  output logic [NO_SLAVES:1][arb_pkg::idx_width(NO_MASTERS)-1:0] grant_master
);

  import arb_pkg::*;

  localparam int M_WIDTH = idx_width(NO_MASTERS);
  localparam int H_WIDTH = $clog2(HOLD_LIMIT + 1);

  logic [NO_SLAVES:1]                busy;
  logic [NO_SLAVES:1][M_WIDTH-1:0]   owner;
  logic [NO_SLAVES:1][H_WIDTH-1:0]   hold_cnt;
  logic [M_WIDTH-1:0]                rr_ptr;

  port_status_t [NO_SLAVES:1]        owner_st;
  logic [NO_SLAVES:1]                waiting;
  logic                              pick_valid;
  logic [M_WIDTH-1:0]                pick_master;
  logic [S_ID_WIDTH-1:0]             pick_slave;

  ////////////////////
  // round robin pick
  ////////////////////

  // search starts just after the last master granted
  always_comb begin : pick_logic
    int idx;
    logic [S_ID_WIDTH-1:0] sid;
    pick_valid  = 1'b0;
    pick_master = '0;
    pick_slave  = '0;
    for (int i = 1; i <= NO_MASTERS; i++) begin
      idx = (int'(rr_ptr) + i) % NO_MASTERS;
      sid = status[idx].id[S_ID_WIDTH-1:0];
      if (!pick_valid && sid != '0 && sid <= NO_SLAVES && !busy[sid]) begin
        pick_valid  = 1'b1;
        pick_master = M_WIDTH'(idx);
        pick_slave  = sid;
      end
    end
  end

  // owner view and pending requests per slave
  always_comb begin : slave_view
    for (int s = 1; s <= NO_SLAVES; s++) begin
      owner_st[s] = status[owner[s]];
      waiting[s]  = 1'b0;
      for (int m = 0; m < NO_MASTERS; m++) begin
        if (status[m].id[S_ID_WIDTH-1:0] == s) waiting[s] = 1'b1;
      end
      grant_valid[s]  = busy[s] && (owner_st[s].com_state == COM);
      grant_master[s] = owner[s];
    end
  end

  always_ff @(posedge clk or negedge rstN) begin : ctrl_regs
    if (!rstN) begin
      busy     <= '0;
      owner    <= '0;
      hold_cnt <= '0;
      rr_ptr   <= '0;
      for (int m = 0; m < NO_MASTERS; m++) cmd[m] <= NONE;
    end else begin
      // commands last a single cycle
      for (int m = 0; m < NO_MASTERS; m++) cmd[m] <= NONE;
      for (int s = 1; s <= NO_SLAVES; s++) begin
        if (busy[s]) begin
          if (owner_st[s].done || owner_st[s].com_state == NAK ||
              owner_st[s].com_state == END_COM) begin
            busy[s]     <= 1'b0;
            hold_cnt[s] <= '0;
          end else if (owner_st[s].com_state == COM) begin
            if (hold_cnt[s] >= HOLD_LIMIT && waiting[s]) begin
              cmd[owner[s]] <= STOP_S;
              hold_cnt[s]   <= '0;
            end else if (hold_cnt[s] < HOLD_LIMIT) begin
              hold_cnt[s] <= hold_cnt[s] + 1'b1;
            end
          end
        end
      end
      if (pick_valid) begin
        busy[pick_slave]     <= 1'b1;
        owner[pick_slave]    <= pick_master;
        hold_cnt[pick_slave] <= '0;
        cmd[pick_master]     <= CLEAR;
        rr_ptr               <= pick_master;
      end
    end
  end

endmodule

// File: logic/a_master_port.sv
`timescale 1ns/1ps

module a_master_port #(
  parameter int S_ID_WIDTH = 2
) (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  port_in,
  output logic                  port_out,
  input  arb_pkg::cmd_t         cmd,
  output arb_pkg::port_status_t status
);

  import arb_pkg::*;

  typedef enum logic [2:0] {
    RST,
    START,
    ALLOC1,
    ALLOC2,
    ACK,
    COM,
    DONE,
    OVER
  } state_t;

  // start pattern plus id
  localparam int BUF_WIDTH = S_ID_WIDTH + 3;

  state_t state;
  state_t next_state;

  logic [BUF_WIDTH-1:0]  input_buf;
  logic [S_ID_WIDTH-1:0] id_q;
  logic                  req_q;
  logic                  done_q;
  logic                  old_q;
  com_state_t            com_q;

  logic [2:0] write_val;
  logic       write;

  logic start_hit;
  logic ack_hit;
  logic nak_hit;
  logic end_hit;
  logic split_hit;

  ////////////////////
  // pattern decode
  ////////////////////

  // newest bit sits at input_buf[0]
  assign start_hit = (input_buf[BUF_WIDTH-1 -: 3] == 3'b111) &&
                     (input_buf[S_ID_WIDTH-1:0] != '0);
  assign ack_hit   = (input_buf[2:0] == 3'b101);
  assign nak_hit   = (input_buf[2:0] == 3'b011);
  assign end_hit   = (input_buf[1:0] == 2'b01);
  assign split_hit = (input_buf[2:0] == 3'b010);

  a_write_buffer code_buffer (
    .clk  (clk),
    .rstN (rstN),
    .din  (write_val),
    .load (write),
    .dout (port_out)
  );

  ////////////////////
  // state machine
  ////////////////////

  always_comb begin : next_state_logic
    next_state = state;
    write      = 1'b0;
    write_val  = END_CODE;
    unique case (state)
      RST: next_state = START;
      START: begin
        if (start_hit) next_state = ALLOC1;
      end
      // id reaches the controller here
      ALLOC1: next_state = ALLOC2;
      ALLOC2: begin
        if (cmd == CLEAR) begin
          write      = 1'b1;
          write_val  = old_q ? GRANT_OLD : GRANT_NEW;
          next_state = ACK;
        end
      end
      ACK: begin
        if (com_q == NAK) begin
          next_state = OVER;
        end else if (com_q == arb_pkg::COM) begin
          write      = 1'b1;
          write_val  = START_COM;
          next_state = COM;
        end
      end
      COM: begin
        if (cmd == STOP_S) begin
          write      = 1'b1;
          write_val  = STOP_SPLIT;
          next_state = DONE;
        end else if (cmd == STOP_P) begin
          write      = 1'b1;
          next_state = OVER;
        end else if (com_q == END_COM) begin
          write      = 1'b1;
          next_state = OVER;
        end
      end
      // wait for the master to confirm the split
      DONE: begin
        if (done_q) next_state = ALLOC2;
      end
      OVER: next_state = START;
      default: next_state = RST;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin : port_regs
    if (!rstN) begin
      state     <= RST;
      input_buf <= '0;
      id_q      <= '0;
      req_q     <= 1'b0;
      done_q    <= 1'b0;
      old_q     <= 1'b0;
      com_q     <= WAIT_ACK;
    end else begin
      state  <= next_state;
      done_q <= 1'b0;
      // flush leftovers so a new start pattern is seen cleanly
      if (state == OVER) begin
        input_buf <= '0;
      end else begin
        input_buf <= {input_buf[BUF_WIDTH-2:0], port_in};
      end
      unique case (state)
        START: begin
          if (start_hit) begin
            id_q  <= input_buf[S_ID_WIDTH-1:0];
            req_q <= 1'b1;
            com_q <= WAIT_ACK;
          end
        end
        ALLOC2: begin
          if (cmd == CLEAR) begin
            req_q <= 1'b0;
            old_q <= 1'b0;
          end
        end
        ACK: begin
          if (com_q == WAIT_ACK) begin
            if (nak_hit) com_q <= NAK;
            else if (ack_hit) com_q <= arb_pkg::COM;
          end
        end
        COM: begin
          // split wins over a coincident end
          if (cmd == STOP_S) old_q <= 1'b1;
          else if (cmd == STOP_P) com_q <= END_COM;
          else if (end_hit) com_q <= END_COM;
        end
        DONE: begin
          if (split_hit && !done_q) begin
            done_q <= 1'b1;
            req_q  <= 1'b1;
            com_q  <= WAIT_ACK;
          end
        end
        default: ;
      endcase
    end
  end

  // id only shows while a grant is wanted
  assign status.id        = req_q ? MAX_ID_WIDTH'(id_q) : '0;
  assign status.com_state = com_q;
  assign status.done      = done_q;

endmodule

// File: logic/a_write_buffer.sv
`timescale 1ns/1ps

module a_write_buffer (
  input  logic       clk,
  input  logic       rstN,
  input  logic [2:0] din,
  input  logic       load,
  output logic       dout
);

  logic [2:0] shift_q;

  // lsb leaves first, zeros follow so the line idles low
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      shift_q <= '0;
    end else if (load) begin
      shift_q <= din;
    end else begin
      shift_q <= {1'b0, shift_q[2:1]};
    end
  end

  assign dout = shift_q[0];

endmodule

// File: logic/arb_pkg.sv
package arb_pkg;

  // widest slave id a port can report
  localparam int MAX_ID_WIDTH = 4;

  // controller to port
  typedef enum logic [1:0] {
    NONE   = 2'b00,
    STOP_S = 2'b01,
    STOP_P = 2'b10,
    CLEAR  = 2'b11
  } cmd_t;

  // port to controller
  typedef enum logic [1:0] {
    END_COM  = 2'b00,
    NAK      = 2'b01,
    WAIT_ACK = 2'b10,
    COM      = 2'b11
  } com_state_t;

  typedef struct packed {
    logic [MAX_ID_WIDTH-1:0] id;
    com_state_t              com_state;
    logic                    done;
  } port_status_t;

  // codes go out lsb first
  localparam logic [2:0] GRANT_NEW  = 3'b110;
  localparam logic [2:0] GRANT_OLD  = 3'b100;
  localparam logic [2:0] START_COM  = 3'b111;
  localparam logic [2:0] STOP_SPLIT = 3'b010;
  localparam logic [2:0] END_CODE   = 3'b000;

  // index width for n items, never zero
  function automatic int idx_width(input int n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

endpackage
